//--- filelist.f
+incdir+include
src/bus_timing_pkg.sv
src/bus_delay_tap.sv
src/cycle_sequencer.sv
src/strobe_decoder.sv
src/bus_timing_top.sv
tb/bus_timing_tb.sv

//--- Bender.yml
package:
  name: bus_timing

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/bus_timing_pkg.sv
      - src/bus_delay_tap.sv
      - src/cycle_sequencer.sv
      - src/strobe_decoder.sv
      - src/bus_timing_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - tb/bus_timing_tb.sv

//--- tb/bus_timing_tb.sv
//************************************************************
// Directed testbench for the bus cycle timing generator
// Reference rules for state order, APR, EADR, DAP and EIOD
// Delay taps, CPU grant and tri-state Q pins
//************************************************************

`include "bus_timing_defs.svh"

module bus_timing_tb import bus_timing_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic OSC;
    logic rst_n;
    logic CC2_n;
    logic CACT_n;
    logic BDRY_n;
    logic CGNT_n;
    logic TERM_n;
    logic IORQ_n;
    logic OE_n;

    wire EADR_n;
    wire EIOD_n;
    wire DAP_n;
    wire APR_n;
    wire Q2_n;
    wire Q1_n;
    wire Q0_n;

    // State code as read back from the inverted Q pins
    wire [2:0] q_code = ~{Q2_n, Q1_n, Q0_n};

    integer seed;

    bus_timing_top uut (
        .OSC    (OSC),
        .rst_n  (rst_n),
        .CC2_n  (CC2_n),
        .CACT_n (CACT_n),
        .BDRY_n (BDRY_n),
        .CGNT_n (CGNT_n),
        .TERM_n (TERM_n),
        .IORQ_n (IORQ_n),
        .OE_n   (OE_n),
        .EADR_n (EADR_n),
        .EIOD_n (EIOD_n),
        .DAP_n  (DAP_n),
        .APR_n  (APR_n),
        .Q2_n   (Q2_n),
        .Q1_n   (Q1_n),
        .Q0_n   (Q0_n)
    );

    // 20 ns period
    initial begin
        OSC = 1'b0;
        forever #10 OSC = ~OSC;
    end

    // Watchdog for the whole run
    initial begin
        repeat (400) @(posedge OSC);
        $display("Timeout: the run did not finish within 400 clock cycles");
        $display("Simulation failed");
        $fatal(1);
    end

    // Loop position 0 is idle, then t through z
    function automatic bt_state_e loop_state(input int idx);
        case (idx % 8)
            0: loop_state = ST_S;
            1: loop_state = ST_T;
            2: loop_state = ST_U;
            3: loop_state = ST_V;
            4: loop_state = ST_W;
            5: loop_state = ST_X;
            6: loop_state = ST_Y;
            default: loop_state = ST_Z;
        endcase
    endfunction

    // APR only in u and v with CACT
    function automatic logic apr_rule(input bt_state_e st, input logic cact);
        apr_rule = cact && (st == ST_U || st == ST_V);
    endfunction

    // EADR from a bus cycle or from the address part of a grant
    function automatic logic eadr_rule(input bt_state_e st, input logic cact,
                                       input logic cact25, input logic cgnt,
                                       input logic cgnt50);
        logic cyc;
        cyc = (st == ST_T || st == ST_U || st == ST_V || st == ST_W) ||
              (st == ST_S && !cact25);
        eadr_rule = (cact && cyc) || (cgnt && !cgnt50);
    endfunction

    task automatic compare(input logic [7:0] got, input logic [7:0] exp,
                           input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %0h expected %0h",
                     $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Returns on the falling edge where the Q pins show target
    task automatic wait_for_state(input bt_state_e target, input int limit);
        int cycles;
        cycles = 0;
        @(negedge OSC);
        while (q_code !== target) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: state pins never showed code %03b", target);
                $display("Simulation failed");
                $fatal(1);
            end
            @(negedge OSC);
        end
    endtask

    task automatic reset_to_idle();
        repeat (2) @(posedge OSC);
        rst_n <= 1'b1;
        @(negedge OSC);
        compare(q_code, ST_S, "state after reset");
        compare(EADR_n, 1'b1, "EADR_n after reset");
        compare(EIOD_n, 1'b1, "EIOD_n after reset");
        compare(DAP_n, 1'b1, "DAP_n after reset");
        compare(APR_n, 1'b1, "APR_n after reset");
    endtask

    // One-cycle CACT, then the loop runs with CACT low
    task automatic short_cact_loop();
        int        step;
        bt_state_e exp_state;
        @(posedge OSC);
        CACT_n <= 1'b0;
        @(negedge OSC);
        compare(q_code, ST_S, "idle before start");
        compare(EADR_n, !eadr_rule(ST_S, 1'b1, 1'b0, 1'b0, 1'b0), "EADR_n on fresh CACT");
        compare(APR_n, !apr_rule(ST_S, 1'b1), "APR_n on fresh CACT");
        @(posedge OSC);
        CACT_n <= 1'b1;
        for (step = 1; step <= 8; step++) begin
            @(negedge OSC);
            exp_state = loop_state(step);
            compare(q_code, exp_state, "loop state order");
            compare(APR_n, !apr_rule(exp_state, 1'b0), "APR_n with CACT low");
            compare(EADR_n, !eadr_rule(exp_state, 1'b0, 1'b0, 1'b0, 1'b0),
                    "EADR_n with CACT low");
        end
    endtask

    // CACT held over the whole loop, cact25 tracked by edge count
    task automatic held_cact_loop();
        int        step;
        bt_state_e exp_state;
        logic      late_cact;
        @(posedge OSC);
        CACT_n <= 1'b0;
        for (step = 0; step <= 8; step++) begin
            @(negedge OSC);
            exp_state = loop_state(step);
            late_cact = (step >= `BT_CACT25_CYCLES);
            compare(q_code, exp_state, "state with CACT held");
            compare(APR_n, !apr_rule(exp_state, 1'b1), "APR_n with CACT held");
            compare(EADR_n, !eadr_rule(exp_state, 1'b1, late_cact, 1'b0, 1'b0),
                    "EADR_n with CACT held");
        end
        @(posedge OSC);
        CACT_n <= 1'b1;
    endtask

    // CACT raised cact25 edges before the loop returns to idle
    task automatic eiod_delay();
        int step;
        @(posedge OSC);
        IORQ_n <= 1'b0;
        CC2_n  <= 1'b0;
        @(posedge OSC);
        CACT_n <= 1'b0;
        @(posedge OSC);
        CACT_n <= 1'b1;
        wait_for_state(loop_state(7 - `BT_CACT25_CYCLES), 12);
        @(posedge OSC);
        CACT_n <= 1'b0;
        for (step = 0; step <= `BT_CACT25_CYCLES; step++) begin
            @(negedge OSC);
            compare(EIOD_n, (step < `BT_CACT25_CYCLES), "EIOD_n after CACT rise");
        end
        compare(q_code, ST_S, "idle when EIOD opens");
        // BDRY closes EIOD once its late copy arrives
        @(posedge OSC);
        BDRY_n <= 1'b0;
        for (step = 0; step <= `BT_BDRY50_CYCLES; step++) begin
            @(negedge OSC);
            compare(EIOD_n, (step >= `BT_BDRY50_CYCLES), "EIOD_n after BDRY");
            compare(q_code, ST_S, "no restart under old CACT");
        end
    endtask

    // DAP stays set on an I/O request until TERM
    task automatic dap_hold_until_term();
        int step;
        int delay;
        compare(DAP_n, 1'b0, "DAP_n set by late CACT in idle");
        @(posedge OSC);
        CACT_n <= 1'b1;
        BDRY_n <= 1'b1;
        delay = 1 + ($unsigned($random(seed)) % 6);
        for (step = 0; step < delay; step++) begin
            @(negedge OSC);
            compare(DAP_n, 1'b0, "DAP_n held after CACT removed");
        end
        @(posedge OSC);
        TERM_n <= 1'b0;
        @(negedge OSC);
        compare(DAP_n, 1'b0, "DAP_n in the TERM cycle");
        @(posedge OSC);
        TERM_n <= 1'b1;
        @(negedge OSC);
        compare(DAP_n, 1'b1, "DAP_n after TERM");
        @(posedge OSC);
        IORQ_n <= 1'b1;
        CC2_n  <= 1'b1;
    endtask

    task automatic cpu_grant_and_tristate();
        int step;
        @(posedge OSC);
        CGNT_n <= 1'b0;
        for (step = 0; step <= `BT_CGNT50_CYCLES; step++) begin
            @(negedge OSC);
            compare(EADR_n, !eadr_rule(ST_S, 1'b0, 1'b0, 1'b1,
                    (step >= `BT_CGNT50_CYCLES)), "EADR_n during CPU grant");
        end
        @(posedge OSC);
        CGNT_n <= 1'b1;
        OE_n   <= 1'b1;
        @(negedge OSC);
        compare({Q2_n, Q1_n, Q0_n}, 3'bzzz, "Q pins with OE_n high");
        compare(EADR_n, 1'b1, "EADR_n after grant");
        @(posedge OSC);
        OE_n <= 1'b0;
        @(negedge OSC);
        compare(q_code, ST_S, "Q pins driven again");
    endtask

    initial begin
        seed   = 32'ha6cf;
        rst_n  = 1'b0;
        CC2_n  = 1'b1;
        CACT_n = 1'b1;
        BDRY_n = 1'b1;
        CGNT_n = 1'b1;
        TERM_n = 1'b1;
        IORQ_n = 1'b1;
        OE_n   = 1'b0;
        reset_to_idle();
        short_cact_loop();
        held_cact_loop();
        eiod_delay();
        dap_hold_until_term();
        cpu_grant_and_tristate();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- src/bus_timing_top.sv
//************************************************************
// Bus cycle timing generator, top level
// Pin inversion, sequencer, three delay taps, strobe decoder
// Tri-state drivers for the state code pins
//************************************************************

`include "bus_timing_defs.svh"

module bus_timing_top import bus_timing_pkg::*; (
    input  logic OSC,
    input  logic rst_n,
    input  logic CC2_n,
    input  logic CACT_n,
    input  logic BDRY_n,
    input  logic CGNT_n,
    input  logic TERM_n,
    input  logic IORQ_n,
    input  logic OE_n,
    output logic EADR_n,
    output logic EIOD_n,
    output logic DAP_n,
    output logic APR_n,
    output logic Q2_n,
    output logic Q1_n,
    output logic Q0_n
);

    // Active-high copies of the bus pins
    logic cc2;
    logic cact;
    logic bdry;
    logic cgnt;
    logic term;
    logic iorq;
    logic oe;

    // Late copies from the taps
    logic cact25;
    logic cgnt50;
    logic bdry50;

    bt_state_e   state;
    logic [2:0]  state_code;

    logic apr;
    logic eadr;
    logic dap;
    logic eiod;

    assign cc2  = ~CC2_n;
    assign cact = ~CACT_n;
    assign bdry = ~BDRY_n;
    assign cgnt = ~CGNT_n;
    assign term = ~TERM_n;
    assign iorq = ~IORQ_n;
    assign oe   = ~OE_n;

    // cact25 also qualifies the sequencer start
    cycle_sequencer u_seq (
        .OSC    (OSC),
        .rst_n  (rst_n),
        .cact   (cact),
        .cact25 (cact25),
        .state  (state)
    );

    // Counter taps in place of the board's delay lines
    bus_delay_tap #(.DELAY(`BT_CACT25_CYCLES)) u_tap_cact (
        .OSC   (OSC),
        .rst_n (rst_n),
        .level (cact),
        .late  (cact25)
    );

    bus_delay_tap #(.DELAY(`BT_CGNT50_CYCLES)) u_tap_cgnt (
        .OSC   (OSC),
        .rst_n (rst_n),
        .level (cgnt),
        .late  (cgnt50)
    );

    bus_delay_tap #(.DELAY(`BT_BDRY50_CYCLES)) u_tap_bdry (
        .OSC   (OSC),
        .rst_n (rst_n),
        .level (bdry),
        .late  (bdry50)
    );

    strobe_decoder u_dec (
        .OSC    (OSC),
        .rst_n  (rst_n),
        .state  (state),
        .cact   (cact),
        .cact25 (cact25),
        .cgnt   (cgnt),
        .cgnt50 (cgnt50),
        .bdry50 (bdry50),
        .iorq   (iorq),
        .term   (term),
        .cc2    (cc2),
        .apr    (apr),
        .eadr   (eadr),
        .dap    (dap),
        .eiod   (eiod)
    );

    // Strobes leave the chip active low
    assign EADR_n = ~eadr;
    assign EIOD_n = ~eiod;
    assign DAP_n  = ~dap;
    assign APR_n  = ~apr;

    // State code on the Q pins, released when OE_n is high
    assign state_code = state;
    assign Q2_n = oe ? ~state_code[2] : 1'bz;
    assign Q1_n = oe ? ~state_code[1] : 1'bz;
    assign Q0_n = oe ? ~state_code[0] : 1'bz;

endmodule

//--- src/strobe_decoder.sv
//************************************************************
// Strobe decoder for APR, EADR, DAP and EIOD
// Combinational from state and taps, plus the DAP hold flop
//************************************************************

module strobe_decoder import bus_timing_pkg::*; (
    input  logic      OSC,
    input  logic      rst_n,
    input  bt_state_e state,
    input  logic      cact,
    input  logic      cact25,
    input  logic      cgnt,
    input  logic      cgnt50,
    input  logic      bdry50,
    input  logic      iorq,
    input  logic      term,
    input  logic      cc2,
    output logic      apr,
    output logic      eadr,
    output logic      dap,
    output logic      eiod
);

    logic in_s;
    logic in_uv;
    logic in_tuvw;
    logic cact_late;
    logic cpu_addr;
    logic dap_set;
    logic dap_hold;
    logic dap_keep;

    // State groups used by more than one strobe
    assign in_s    = (state == ST_S);
    assign in_uv   = (state == ST_U) || (state == ST_V);
    assign in_tuvw = (state == ST_T) || (state == ST_U) ||
                     (state == ST_V) || (state == ST_W);

    // CACT that has been high long enough for the slow data path
    assign cact_late = cact && cact25;

    // Address present only in the middle of the loop
    assign apr = cact && in_uv;

    // Address part of a CPU grant, ends when the late grant arrives
    assign cpu_addr = cgnt && !cgnt50;

    // Address enable starts already in s on a fresh CACT
    // so the address is on the bus one step before t
    assign eadr = (cact && in_tuvw) ||
                  (cact && in_s && !cact25) ||
                  cpu_addr;

    // Data present starts back in idle once CACT is old enough
    assign dap_set = in_s && cact_late;

    // On I/O requests data stays present until TERM
    assign dap = dap_set || dap_hold;

    // Hold condition, dropped by TERM or by losing IORQ or CC2
    assign dap_keep = dap && !term && iorq && cc2;

    always_ff @(posedge OSC or negedge rst_n) begin
        if (!rst_n) begin
            dap_hold <= 1'b0;
        end else begin
            dap_hold <= dap_keep;
        end
    end

    // I/O data enable, delayed front flank via cact25
    // BDRY50 closes it again at the end of the bus cycle
    assign eiod = iorq && cc2 && in_s && cact_late && !bdry50;

endmodule

//--- src/cycle_sequencer.sv
//************************************************************
// Eight-state bus cycle sequencer
// Leaves idle on a fresh CACT, then runs the loop unconditionally
//************************************************************

module cycle_sequencer import bus_timing_pkg::*; (
    input  logic      OSC,
    input  logic      rst_n,
    input  logic      cact,
    input  logic      cact25,
    output bt_state_e state
);

    bt_state_e state_next;
    logic      cact_fresh;

    // CACT is fresh while its delayed copy has not caught up yet
    // A CACT still held after a full loop does not restart it
    assign cact_fresh = cact && !cact25;

    // Next state, only the idle state looks at the inputs
    always_comb begin
        case (state)
            ST_S: begin
                if (cact_fresh) begin
                    state_next = ST_T;
                end else begin
                    state_next = ST_S;
                end
            end
            ST_T: state_next = ST_U;
            ST_U: state_next = ST_V;
            ST_V: state_next = ST_W;
            ST_W: state_next = ST_X;
            ST_X: state_next = ST_Y;
            ST_Y: state_next = ST_Z;
            // z closes the loop back to idle
            ST_Z: state_next = ST_S;
            default: state_next = ST_S;
        endcase
    end

    // State register, one step per OSC edge
    always_ff @(posedge OSC or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_S;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- src/bus_delay_tap.sv
//************************************************************
// Delay tap for a level input
// Saturating counter, late copy rises after DELAY edges
//************************************************************

`include "bus_timing_defs.svh"

module bus_delay_tap #(
    parameter int DELAY = 2
) (
    input  logic OSC,
    input  logic rst_n,
    input  logic level,
    output logic late
);

    // Terminal count, sized to the counter
    localparam logic [`BT_TAP_WIDTH-1:0] LIMIT = `BT_TAP_WIDTH'(DELAY);

    logic [`BT_TAP_WIDTH-1:0] count;

    // Counts edges with level continuously high
    // Any low cycle starts the measurement over
    always_ff @(posedge OSC or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!level) begin
            count <= '0;
        end else if (count != LIMIT) begin
            count <= count + 1'b1;
        end
    end

    // Late copy drops together with the input
    // no trailing delay on the falling edge
    assign late = level && (count == LIMIT);

endmodule

//--- src/bus_timing_pkg.sv
//************************************************************
// Shared types for the bus timing generator
// State codes of the eight-state cycle sequencer
//************************************************************

package bus_timing_pkg;

    // Loop order is s t u v w x y z, one bit flips per step
    // Codes follow the original board so the Q pins keep their meaning
    typedef enum logic [2:0] {
        // Idle, waiting for a fresh CACT
        ST_S = 3'b000,
        ST_T = 3'b001,
        // Address present window is u and v
        ST_U = 3'b011,
        ST_V = 3'b010,
        ST_W = 3'b110,
        ST_X = 3'b111,
        ST_Y = 3'b101,
        // Last step, always returns to s
        ST_Z = 3'b100
    } bt_state_e;

endpackage

//--- include/bus_timing_defs.svh
//************************************************************
// Delay-tap lengths for the bus timing generator
// Counter width shared by all tap instances
//************************************************************

`ifndef BUS_TIMING_DEFS_SVH
`define BUS_TIMING_DEFS_SVH

// Width of the saturating tap counters
`define BT_TAP_WIDTH 4

// OSC edges CACT must stay high before cact25 rises
`define BT_CACT25_CYCLES 2

// OSC edges for the late copies of CGNT and BDRY
`define BT_CGNT50_CYCLES 3
`define BT_BDRY50_CYCLES 3

`endif
